// ==== src/zynq_glue_pkg.sv ====
package zynq_glue_pkg;

   ////////////////////////////////////////////////////////////
   // widths and constants
   ////////////////////////////////////////////////////////////
   localparam int DATA_W      = 32;
   localparam int ADDR_W      = 32;
   localparam int HOST_ADDR_W = 4;
   localparam int NUM_REGIONS = 128;
   localparam int REGION_W    = $clog2(NUM_REGIONS);
   localparam int INSTRET_W   = 64;

   // base of the core's DRAM window
   localparam logic [ADDR_W-1:0] BP_DRAM_BASE = 32'h8000_0000;

   // host register map, written registers first
   localparam logic [HOST_ADDR_W-1:0] REG_CTRL       = 4'd0;
   localparam logic [HOST_ADDR_W-1:0] REG_DRAM_INIT  = 4'd1;
   localparam logic [HOST_ADDR_W-1:0] REG_DRAM_BASE  = 4'd2;
   localparam logic [HOST_ADDR_W-1:0] REG_INSTRET_LO = 4'd3;
   localparam logic [HOST_ADDR_W-1:0] REG_INSTRET_HI = 4'd4;
   localparam logic [HOST_ADDR_W-1:0] REG_PROF0      = 4'd5;
   localparam logic [HOST_ADDR_W-1:0] REG_PROF1      = 4'd6;
   localparam logic [HOST_ADDR_W-1:0] REG_PROF2      = 4'd7;
   localparam logic [HOST_ADDR_W-1:0] REG_PROF3      = 4'd8;

   ////////////////////////////////////////////////////////////
   // types
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      logic                   wr;
      logic                   rd;
      logic [HOST_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]      wdata;
   } host_req_t;

   // region sits at address bits 29:23
   typedef struct packed {
      logic [1:0]                     hi;
      logic [REGION_W-1:0]            region;
      logic [ADDR_W-REGION_W-3:0]     offset;
   } dram_addr_fields_t;

   typedef union packed {
      logic [ADDR_W-1:0] raw;
      dram_addr_fields_t fields;
   } dram_addr_u;

   typedef struct packed {
      logic       valid;
      dram_addr_u addr;
   } dram_req_t;

   // host-written words as seen by the readback mux
   typedef struct packed {
      logic [DATA_W-1:0] ctrl;
      logic [DATA_W-1:0] dram_init;
      logic [DATA_W-1:0] dram_base;
   } ctrl_words_t;

endpackage

// ==== src/host_csr_ctrl.sv ====
`timescale 1ns/100ps

module host_csr_ctrl (
   input  logic                                  aclk,
   input  logic                                  rst_i,
   input  zynq_glue_pkg::host_req_t              host_req_i,
   output logic                                  sys_rst_o,
   output logic                                  dram_init_o,
   output logic [zynq_glue_pkg::ADDR_W-1:0]      dram_base_o,
   output logic                                  rd_en_o,
   output logic [zynq_glue_pkg::HOST_ADDR_W-1:0] rd_idx_o,
   output zynq_glue_pkg::ctrl_words_t            ctrl_words_o
);

   ////////////////////////////////////////////////////////////
   // write decode
   ////////////////////////////////////////////////////////////
   logic wr_ctrl;
   logic wr_dram_init;
   logic wr_dram_base;

   logic [zynq_glue_pkg::DATA_W-1:0] ctrl_r;
   logic [zynq_glue_pkg::DATA_W-1:0] dram_init_r;
   logic [zynq_glue_pkg::ADDR_W-1:0] dram_base_r;

   always_comb begin
      wr_ctrl      = host_req_i.wr && (host_req_i.addr == zynq_glue_pkg::REG_CTRL);
      wr_dram_init = host_req_i.wr && (host_req_i.addr == zynq_glue_pkg::REG_DRAM_INIT);
      wr_dram_base = host_req_i.wr && (host_req_i.addr == zynq_glue_pkg::REG_DRAM_BASE);
   end

   // writes to read-only or unmapped indices are dropped
   always_ff @(posedge aclk) begin
      if (rst_i) begin
         ctrl_r      <= '0;
         dram_init_r <= '0;
         dram_base_r <= '0;
      end else begin
         if (wr_ctrl) begin
            ctrl_r <= host_req_i.wdata;
         end
         if (wr_dram_init) begin
            dram_init_r <= host_req_i.wdata;
         end
         if (wr_dram_base) begin
            dram_base_r <= host_req_i.wdata;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // register outputs
   ////////////////////////////////////////////////////////////

   // bit 0 of the control word is the system reset, low true
   assign sys_rst_o   = ~ctrl_r[0];
   assign dram_init_o = dram_init_r[0];
   assign dram_base_o = dram_base_r;

   always_comb begin
      ctrl_words_o.ctrl      = ctrl_r;
      ctrl_words_o.dram_init = dram_init_r;
      ctrl_words_o.dram_base = dram_base_r;
   end

   ////////////////////////////////////////////////////////////
   // read request
   ////////////////////////////////////////////////////////////

   // the readback stage registers this strobe, so data shows up
   // one cycle after rd; a colliding write suppresses the read
   assign rd_en_o  = host_req_i.rd & ~host_req_i.wr;
   assign rd_idx_o = host_req_i.addr;

   // host side never issues a write and a read in the same cycle
   a_no_wr_rd_collision: assert property (
      @(posedge aclk) disable iff (rst_i)
      !(host_req_i.wr && host_req_i.rd)
   ) else $error("host_csr_ctrl: wr and rd asserted together");

endmodule

// ==== src/dram_addr_remap.sv ====
`timescale 1ns/100ps

module dram_addr_remap #(
   parameter logic [zynq_glue_pkg::ADDR_W-1:0] BP_DRAM_BASE_P = zynq_glue_pkg::BP_DRAM_BASE
) (
   input  zynq_glue_pkg::dram_req_t           req_i,
   input  logic [zynq_glue_pkg::ADDR_W-1:0]   dram_base_i,
   output zynq_glue_pkg::dram_req_t           req_o
);

   ////////////////////////////////////////////////////////////
   // core window to host physical address
   ////////////////////////////////////////////////////////////

   // offset inside the core's DRAM window
   logic [zynq_glue_pkg::ADDR_W-1:0] window_offset;

   // xor drops the window base since the base is a single bit
   assign window_offset = req_i.addr.raw ^ BP_DRAM_BASE_P;

   always_comb begin
      req_o.valid    = req_i.valid;
      req_o.addr.raw = window_offset + dram_base_i;
   end

endmodule

// ==== src/dram_region_profiler.sv ====
`timescale 1ns/100ps

module dram_region_profiler (
   input  logic                                  aclk,
   input  logic                                  rst_i,
   input  logic                                  sys_rst_i,
   input  zynq_glue_pkg::dram_req_t              aw_i,
   input  zynq_glue_pkg::dram_req_t              ar_i,
   output logic [zynq_glue_pkg::NUM_REGIONS-1:0] bitmap_o
);

   logic [zynq_glue_pkg::NUM_REGIONS-1:0] aw_hit;
   logic [zynq_glue_pkg::NUM_REGIONS-1:0] ar_hit;
   logic [zynq_glue_pkg::NUM_REGIONS-1:0] bitmap_r;

   ////////////////////////////////////////////////////////////
   // one-hot region of each request
   ////////////////////////////////////////////////////////////
   always_comb begin
      aw_hit = '0;
      ar_hit = '0;
      aw_hit[aw_i.addr.fields.region] = aw_i.valid;
      ar_hit[ar_i.addr.fields.region] = ar_i.valid;
   end

   // sticky bits, cleared only by a reset
   always_ff @(posedge aclk) begin
      if (rst_i || sys_rst_i) begin
         bitmap_r <= '0;
      end else begin
         bitmap_r <= bitmap_r | aw_hit | ar_hit;
      end
   end

   assign bitmap_o = bitmap_r;

   // once the system runs, a region bit never drops
   a_bits_sticky: assert property (
      @(posedge aclk)
      (!rst_i && !sys_rst_i) |=> ((bitmap_r & $past(bitmap_r)) == $past(bitmap_r))
   ) else $error("dram_region_profiler: region bit cleared outside reset");

endmodule

// ==== src/instret_counter.sv ====
`timescale 1ns/100ps

module instret_counter (
   input  logic                                aclk,
   input  logic                                rst_i,
   input  logic                                sys_rst_i,
   input  logic                                retire_i,
   output logic [zynq_glue_pkg::INSTRET_W-1:0] count_o
);

   logic [zynq_glue_pkg::INSTRET_W-1:0] count_r;

   // pulses are dropped while the core is held in reset
   always_ff @(posedge aclk) begin
      if (rst_i || sys_rst_i) begin
         count_r <= '0;
      end else if (retire_i) begin
         count_r <= count_r + 1'b1;
      end
   end

   assign count_o = count_r;

endmodule

// ==== src/status_readback.sv ====
`timescale 1ns/100ps

module status_readback (
   input  logic                                  aclk,
   input  logic                                  rst_i,
   input  logic                                  rd_en_i,
   input  logic [zynq_glue_pkg::HOST_ADDR_W-1:0] rd_idx_i,
   input  zynq_glue_pkg::ctrl_words_t            ctrl_words_i,
   input  logic [zynq_glue_pkg::INSTRET_W-1:0]   instret_i,
   input  logic [zynq_glue_pkg::NUM_REGIONS-1:0] bitmap_i,
   output logic                                  rd_valid_o,
   output logic [zynq_glue_pkg::DATA_W-1:0]      rd_data_o
);

   localparam int W = zynq_glue_pkg::DATA_W;

   logic [W-1:0] sel_word;

   ////////////////////////////////////////////////////////////
   // word select
   ////////////////////////////////////////////////////////////
   always_comb begin
      case (rd_idx_i)
         zynq_glue_pkg::REG_CTRL:       sel_word = ctrl_words_i.ctrl;
         zynq_glue_pkg::REG_DRAM_INIT:  sel_word = ctrl_words_i.dram_init;
         zynq_glue_pkg::REG_DRAM_BASE:  sel_word = ctrl_words_i.dram_base;
         zynq_glue_pkg::REG_INSTRET_LO: sel_word = instret_i[0 +: W];
         zynq_glue_pkg::REG_INSTRET_HI: sel_word = instret_i[W +: W];
         // profiler words, low word first
         zynq_glue_pkg::REG_PROF0:      sel_word = bitmap_i[0 +: W];
         zynq_glue_pkg::REG_PROF1:      sel_word = bitmap_i[W +: W];
         zynq_glue_pkg::REG_PROF2:      sel_word = bitmap_i[2*W +: W];
         zynq_glue_pkg::REG_PROF3:      sel_word = bitmap_i[3*W +: W];
         default:                       sel_word = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // output stage
   ////////////////////////////////////////////////////////////
   always_ff @(posedge aclk) begin
      if (rst_i) begin
         rd_valid_o <= 1'b0;
      end else begin
         rd_valid_o <= rd_en_i;
      end
   end

   // data only meaningful alongside rd_valid_o
   always_ff @(posedge aclk) begin
      if (rd_en_i) begin
         rd_data_o <= sel_word;
      end
   end

endmodule

// ==== src/zynq_glue_top.sv ====
`timescale 1ns/100ps

module zynq_glue_top (
   input  logic                                  aclk,
   input  logic                                  rst_i,

   // host register port
   input  zynq_glue_pkg::host_req_t              host_req_i,
   output logic                                  rd_valid_o,
   output logic [zynq_glue_pkg::DATA_W-1:0]      rd_data_o,

   // core side
   input  logic                                  retire_i,
   input  zynq_glue_pkg::dram_req_t              bp_aw_i,
   input  zynq_glue_pkg::dram_req_t              bp_ar_i,

   // host memory side
   output zynq_glue_pkg::dram_req_t              m_aw_o,
   output zynq_glue_pkg::dram_req_t              m_ar_o,

   output logic                                  sys_reset_o,
   output logic                                  dram_init_o
);

   logic [zynq_glue_pkg::ADDR_W-1:0]      dram_base;
   logic                                  rd_en;
   logic [zynq_glue_pkg::HOST_ADDR_W-1:0] rd_idx;
   zynq_glue_pkg::ctrl_words_t            ctrl_words;
   logic [zynq_glue_pkg::INSTRET_W-1:0]   instret;
   logic [zynq_glue_pkg::NUM_REGIONS-1:0] bitmap;

   ////////////////////////////////////////////////////////////
   // host registers
   ////////////////////////////////////////////////////////////
   host_csr_ctrl csr_i (
      .aclk         (aclk),
      .rst_i        (rst_i),
      .host_req_i   (host_req_i),
      .sys_rst_o    (sys_reset_o),
      .dram_init_o  (dram_init_o),
      .dram_base_o  (dram_base),
      .rd_en_o      (rd_en),
      .rd_idx_o     (rd_idx),
      .ctrl_words_o (ctrl_words)
   );

   ////////////////////////////////////////////////////////////
   // address translation, write and read paths
   ////////////////////////////////////////////////////////////
   dram_addr_remap #(
      .BP_DRAM_BASE_P (zynq_glue_pkg::BP_DRAM_BASE)
   ) aw_remap_i (
      .req_i       (bp_aw_i),
      .dram_base_i (dram_base),
      .req_o       (m_aw_o)
   );

   dram_addr_remap #(
      .BP_DRAM_BASE_P (zynq_glue_pkg::BP_DRAM_BASE)
   ) ar_remap_i (
      .req_i       (bp_ar_i),
      .dram_base_i (dram_base),
      .req_o       (m_ar_o)
   );

   ////////////////////////////////////////////////////////////
   // instrumentation
   ////////////////////////////////////////////////////////////

   // profiler sees core addresses, before translation
   dram_region_profiler profiler_i (
      .aclk      (aclk),
      .rst_i     (rst_i),
      .sys_rst_i (sys_reset_o),
      .aw_i      (bp_aw_i),
      .ar_i      (bp_ar_i),
      .bitmap_o  (bitmap)
   );

   instret_counter instret_i (
      .aclk      (aclk),
      .rst_i     (rst_i),
      .sys_rst_i (sys_reset_o),
      .retire_i  (retire_i),
      .count_o   (instret)
   );

   status_readback readback_i (
      .aclk         (aclk),
      .rst_i        (rst_i),
      .rd_en_i      (rd_en),
      .rd_idx_i     (rd_idx),
      .ctrl_words_i (ctrl_words),
      .instret_i    (instret),
      .bitmap_i     (bitmap),
      .rd_valid_o   (rd_valid_o),
      .rd_data_o    (rd_data_o)
   );

endmodule

// ==== dv/zynq_glue_tb.sv ====
`timescale 1ns/100ps

module zynq_glue_tb;

   localparam logic [31:0] CORE_DRAM_BASE = 32'h8000_0000;
   localparam int N_ADDR     = 100;
   localparam int N_REQ      = 200;
   localparam int MAX_RETIRE = 200;
   localparam int N_HELD     = 50;
   // stimulus cycles twice over, plus room for the register reads and writes
   localparam int TIMEOUT_CYCLES = 2 * (N_ADDR + N_REQ + 2 * MAX_RETIRE + N_HELD) + 500;

   localparam zynq_glue_pkg::host_req_t HOST_IDLE = '0;

   logic aclk = 1'b0;
   logic rst_i;

   zynq_glue_pkg::host_req_t         host_req;
   logic                             rd_valid;
   logic [zynq_glue_pkg::DATA_W-1:0] rd_data;
   logic                             retire;
   zynq_glue_pkg::dram_req_t         bp_aw;
   zynq_glue_pkg::dram_req_t         bp_ar;
   zynq_glue_pkg::dram_req_t         m_aw;
   zynq_glue_pkg::dram_req_t         m_ar;
   logic                             sys_reset;
   logic                             dram_init;

   // testbench models of the host-visible state
   logic [31:0]  ctrl_model    = '0;
   logic [31:0]  init_model    = '0;
   logic [31:0]  base_model    = '0;
   logic [63:0]  instret_model = '0;
   logic [127:0] bitmap_model  = '0;

   integer      seed      = 32'h68fb84a5;
   int          err_cnt   = 0;
   int unsigned cycle_cnt = 0;

   always #4 aclk = ~aclk;

   zynq_glue_top zynq_glue_top_i (
      .aclk        (aclk),
      .rst_i       (rst_i),
      .host_req_i  (host_req),
      .rd_valid_o  (rd_valid),
      .rd_data_o   (rd_data),
      .retire_i    (retire),
      .bp_aw_i     (bp_aw),
      .bp_ar_i     (bp_ar),
      .m_aw_o      (m_aw),
      .m_ar_o      (m_ar),
      .sys_reset_o (sys_reset),
      .dram_init_o (dram_init)
   );

   ////////////////////////////////////////////////////////////
   // reference and checking
   ////////////////////////////////////////////////////////////

   // strip the core window base, then move to the programmed host base
   function automatic logic [31:0] ref_remap(input logic [31:0] core_addr,
                                             input logic [31:0] base);
      return (core_addr ^ CORE_DRAM_BASE) + base;
   endfunction

   function automatic logic [31:0] expected_word(input logic [3:0] idx);
      case (idx)
         zynq_glue_pkg::REG_CTRL:       return ctrl_model;
         zynq_glue_pkg::REG_DRAM_INIT:  return init_model;
         zynq_glue_pkg::REG_DRAM_BASE:  return base_model;
         zynq_glue_pkg::REG_INSTRET_LO: return instret_model[31:0];
         zynq_glue_pkg::REG_INSTRET_HI: return instret_model[63:32];
         zynq_glue_pkg::REG_PROF0:      return bitmap_model[31:0];
         zynq_glue_pkg::REG_PROF1:      return bitmap_model[63:32];
         zynq_glue_pkg::REG_PROF2:      return bitmap_model[95:64];
         zynq_glue_pkg::REG_PROF3:      return bitmap_model[127:96];
         default:                       return 32'd0;
      endcase
   endfunction

   task automatic check_eq(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
      if (actual !== expected) begin
         err_cnt++;
         $display("CHECK FAILED at time %0t: %s expected 0x%0h actual 0x%0h",
                  $time, name, expected, actual);
         $display("tests failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   // translated requests are combinational, compared mid-cycle
   always @(negedge aclk) begin
      if (!rst_i) begin
         check_eq("m_aw_o.valid", 64'(bp_aw.valid), 64'(m_aw.valid));
         check_eq("m_aw_o.addr", 64'(ref_remap(bp_aw.addr.raw, base_model)),
                  64'(m_aw.addr.raw));
         check_eq("m_ar_o.valid", 64'(bp_ar.valid), 64'(m_ar.valid));
         check_eq("m_ar_o.addr", 64'(ref_remap(bp_ar.addr.raw, base_model)),
                  64'(m_ar.addr.raw));
      end
   end

   always @(posedge aclk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("tests failed");
         $fatal(1, "timeout");
      end
   end

   ////////////////////////////////////////////////////////////
   // host and core drivers
   ////////////////////////////////////////////////////////////
   task automatic write_reg(input logic [3:0] idx, input logic [31:0] data);
      @(posedge aclk);
      host_req <= {1'b1, 1'b0, idx, data};
      @(negedge aclk);
      // old values hold until the write edge
      check_eq("sys_reset_o", 64'(!ctrl_model[0]), 64'(sys_reset));
      check_eq("dram_init_o", 64'(init_model[0]), 64'(dram_init));
      @(posedge aclk);
      host_req <= HOST_IDLE;
      case (idx)
         zynq_glue_pkg::REG_CTRL:      ctrl_model = data;
         zynq_glue_pkg::REG_DRAM_INIT: init_model = data;
         zynq_glue_pkg::REG_DRAM_BASE: base_model = data;
         default: ;
      endcase
      if (!ctrl_model[0]) begin
         instret_model = '0;
         bitmap_model  = '0;
      end
      @(negedge aclk);
      check_eq("sys_reset_o", 64'(!ctrl_model[0]), 64'(sys_reset));
      check_eq("dram_init_o", 64'(init_model[0]), 64'(dram_init));
   endtask

   task automatic read_check(input logic [3:0] idx);
      logic [31:0] expected;
      expected = expected_word(idx);
      @(posedge aclk);
      host_req <= {1'b0, 1'b1, idx, 32'd0};
      @(negedge aclk);
      check_eq("rd_valid_o", 64'd0, 64'(rd_valid));
      @(posedge aclk);
      host_req <= HOST_IDLE;
      @(negedge aclk);
      check_eq("rd_valid_o", 64'd1, 64'(rd_valid));
      check_eq($sformatf("rd_data_o[reg %0d]", idx), 64'(expected), 64'(rd_data));
   endtask

   task automatic read_all_status();
      read_check(zynq_glue_pkg::REG_INSTRET_LO);
      read_check(zynq_glue_pkg::REG_INSTRET_HI);
      read_check(zynq_glue_pkg::REG_PROF0);
      read_check(zynq_glue_pkg::REG_PROF1);
      read_check(zynq_glue_pkg::REG_PROF2);
      read_check(zynq_glue_pkg::REG_PROF3);
   endtask

   // one core cycle; the models only move while the system runs
   task automatic drive_cycle(input logic aw_v, input logic [31:0] aw_a,
                              input logic ar_v, input logic [31:0] ar_a,
                              input logic pulse);
      @(posedge aclk);
      bp_aw  <= {aw_v, aw_a};
      bp_ar  <= {ar_v, ar_a};
      retire <= pulse;
      if (ctrl_model[0]) begin
         if (aw_v) bitmap_model[aw_a[29:23]] = 1'b1;
         if (ar_v) bitmap_model[ar_a[29:23]] = 1'b1;
         if (pulse) instret_model = instret_model + 64'd1;
      end
   endtask

   task automatic random_requests(input int n, input logic pulse);
      logic [31:0] aw_a;
      logic [31:0] ar_a;
      logic [31:0] v;
      for (int i = 0; i < n; i++) begin
         aw_a = $random(seed);
         ar_a = $random(seed);
         v    = $random(seed);
         drive_cycle(v[0], aw_a, v[1], ar_a, pulse);
      end
      drive_cycle(1'b0, 32'd0, 1'b0, 32'd0, 1'b0);
   endtask

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////
   initial begin
      logic [31:0] r;
      int unsigned n_pulses;
      rst_i    = 1'b1;
      host_req = HOST_IDLE;
      retire   = 1'b0;
      bp_aw    = '0;
      bp_ar    = '0;
      repeat (4) @(posedge aclk);
      rst_i <= 1'b0;

      // reset state, every index reads zero
      @(negedge aclk);
      check_eq("sys_reset_o", 64'd1, 64'(sys_reset));
      check_eq("dram_init_o", 64'd0, 64'(dram_init));
      for (int idx = 0; idx < 16; idx++) begin
         read_check(4'(idx));
      end

      // written registers read back
      for (int round = 0; round < 4; round++) begin
         r = $random(seed);
         write_reg(zynq_glue_pkg::REG_CTRL, r);
         r = $random(seed);
         write_reg(zynq_glue_pkg::REG_DRAM_INIT, r);
         r = $random(seed);
         write_reg(zynq_glue_pkg::REG_DRAM_BASE, r);
         read_check(zynq_glue_pkg::REG_CTRL);
         read_check(zynq_glue_pkg::REG_DRAM_INIT);
         read_check(zynq_glue_pkg::REG_DRAM_BASE);
      end

      // address translation for a fresh base
      r = $random(seed);
      write_reg(zynq_glue_pkg::REG_DRAM_BASE, r);
      random_requests(N_ADDR, 1'b0);

      // release the system and profile requests
      write_reg(zynq_glue_pkg::REG_CTRL, 32'd1);
      read_all_status();
      random_requests(N_REQ, 1'b0);
      read_all_status();

      // retire pulses with random gaps
      r        = $random(seed);
      n_pulses = (r % 32'(MAX_RETIRE)) + 1;
      for (int unsigned i = 0; i < n_pulses; i++) begin
         r = $random(seed);
         drive_cycle(1'b0, 32'd0, 1'b0, 32'd0, 1'b1);
         if (r[0]) drive_cycle(1'b0, 32'd0, 1'b0, 32'd0, 1'b0);
      end
      drive_cycle(1'b0, 32'd0, 1'b0, 32'd0, 1'b0);
      read_all_status();

      // system reset clears both, and holds them while asserted
      write_reg(zynq_glue_pkg::REG_CTRL, 32'd0);
      read_all_status();
      random_requests(N_HELD, 1'b1);
      read_all_status();

      if (err_cnt == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
src/zynq_glue_pkg.sv
src/host_csr_ctrl.sv
src/dram_addr_remap.sv
src/dram_region_profiler.sv
src/instret_counter.sv
src/status_readback.sv
src/zynq_glue_top.sv
dv/zynq_glue_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench, pass or fail is taken from the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
   -f tb.f --top-module zynq_glue_tb -o zynq_glue_sim \
   && ./obj_dir/zynq_glue_sim 2>&1 | tee sim.log

grep -q "all tests passed" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
